//--- axi_read_burst.sv
// ##########################################################
// AXI read burst engine
// AR phase, then R beats forwarded to the read buffer
// until the beat with rlast
// ##########################################################

module axi_read_burst
  import mem_channel_pkg::*;
  (
    input  logic      clk_i
    , input  logic      reset_i

    , input  logic      start_i
    , input  axi_addr_t addr_i

    , output axi_addr_t axi_araddr_o
    , output logic      axi_arvalid_o
    , input  logic      axi_arready_i

    , input  word_t     axi_rdata_i
    , input  logic      axi_rlast_i
    , input  logic      axi_rvalid_i
    , output logic      axi_rready_o

    , output word_t     beat_o
    , output logic      beat_v_o
    , input  logic      beat_ready_i

    , output logic      done_o
  );

  typedef enum logic [1:0] {
    idle_s
    , addr_s
    , data_s
  } state_e;

  state_e state_r;
  axi_addr_t addr_r;

  logic in_data;
  logic r_fire;

  assign in_data = (state_r == data_s);

  assign axi_araddr_o  = addr_r;
  assign axi_arvalid_o = (state_r == addr_s);

  // take a beat only while the buffer has room
  assign axi_rready_o = in_data & beat_ready_i;
  assign beat_o       = axi_rdata_i;
  assign beat_v_o     = in_data & axi_rvalid_i;

  assign r_fire = axi_rvalid_i & axi_rready_o;
  assign done_o = r_fire & axi_rlast_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= idle_s;
    end else begin
      case (state_r)
        idle_s: begin
          if (start_i)
            state_r <= addr_s;
        end
        addr_s: begin
          if (axi_arready_i)
            state_r <= data_s;
        end
        data_s: begin
          if (done_o)
            state_r <= idle_s;
        end
        default: state_r <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && (state_r == idle_s))
      addr_r <= addr_i;
  end

endmodule

//--- axi_write_burst.sv
// ##########################################################
// AXI write burst engine
// AW phase, burst_len_c W beats from the DMA write data
// port, then the wait for the B response
// ##########################################################

module axi_write_burst
  import mem_channel_pkg::*;
  (
    input  logic      clk_i
    , input  logic      reset_i

    , input  logic      start_i
    , input  axi_addr_t addr_i

    , input  word_t     wdata_i
    , input  logic      wdata_v_i
    , output logic      wdata_yumi_o

    , output axi_addr_t axi_awaddr_o
    , output logic      axi_awvalid_o
    , input  logic      axi_awready_i

    , output word_t     axi_wdata_o
    , output logic      axi_wlast_o
    , output logic      axi_wvalid_o
    , input  logic      axi_wready_i

    , input  logic      axi_bvalid_i
    , output logic      axi_bready_o

    , output logic      done_o
  );

  typedef enum logic [1:0] {
    idle_s
    , addr_s
    , data_s
    , resp_s
  } state_e;

  state_e state_r;
  axi_addr_t addr_r;
  logic [beat_cnt_width_c-1:0] beat_cnt_r;

  logic last_beat;
  logic w_fire;

  assign last_beat = (beat_cnt_r == beat_cnt_width_c'(burst_len_c - 1));

  assign axi_awaddr_o  = addr_r;
  assign axi_awvalid_o = (state_r == addr_s);

  // W valid follows the DMA word valid
  assign axi_wdata_o  = wdata_i;
  assign axi_wvalid_o = (state_r == data_s) & wdata_v_i;
  assign axi_wlast_o  = axi_wvalid_o & last_beat;

  assign w_fire       = axi_wvalid_o & axi_wready_i;
  assign wdata_yumi_o = w_fire;

  // responses are always accepted
  assign axi_bready_o = 1'b1;
  assign done_o       = (state_r == resp_s) & axi_bvalid_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= idle_s;
      beat_cnt_r <= '0;
    end else begin
      case (state_r)
        idle_s: begin
          if (start_i)
            state_r <= addr_s;
        end
        addr_s: begin
          if (axi_awready_i) begin
            state_r    <= data_s;
            beat_cnt_r <= '0;
          end
        end
        data_s: begin
          if (w_fire) begin
            beat_cnt_r <= beat_cnt_r + 1'b1;
            if (last_beat)
              state_r <= resp_s;
          end
        end
        resp_s: begin
          if (axi_bvalid_i)
            state_r <= idle_s;
        end
        default: state_r <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && (state_r == idle_s))
      addr_r <= addr_i;
  end

endmodule

//--- dma_dispatch.sv
// ##########################################################
// packet dispatcher: pops the queue head, remaps its
// address into the slice of the requesting cache and starts
// the matching burst engine, one burst at a time
// ##########################################################

module dma_dispatch
  import mem_channel_pkg::*;
  #(parameter mem_size_lg_p = 20
    , parameter vcache_sel_width_p = 3
    , parameter ruche_sel_width_p = 1
  )
  (
    input  logic      clk_i
    , input  logic      reset_i

    , input  dma_pkt_t  pkt_i
    , input  logic      pkt_v_i
    , output logic      pkt_yumi_o

    , output logic      wr_start_o
    , output logic      rd_start_o
    , output axi_addr_t addr_o

    , input  logic      wr_done_i
    , input  logic      rd_done_i
  );

  // address bits kept from the packet
  localparam int offset_width_lp = mem_size_lg_p - vcache_sel_width_p;

  logic busy_r;
  logic wr_start_r;
  logic rd_start_r;
  axi_addr_t addr_r;

  logic idle;
  logic [vcache_sel_width_p-1:0] cache_sel;
  logic [offset_width_lp-1:0] block_offset;
  axi_addr_t remap_addr;

  // cache index from the coordinate, above the ruche select bits
  assign cache_sel    = pkt_i.src_cord[ruche_sel_width_p +: vcache_sel_width_p];
  assign block_offset = pkt_i.addr[0 +: offset_width_lp];
  assign remap_addr   = axi_addr_t'({cache_sel, block_offset});

  // free again in the cycle the engine finishes
  assign idle       = ~busy_r | wr_done_i | rd_done_i;
  assign pkt_yumi_o = pkt_v_i & idle;

  assign wr_start_o = wr_start_r;
  assign rd_start_o = rd_start_r;
  assign addr_o     = addr_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r     <= 1'b0;
      wr_start_r <= 1'b0;
      rd_start_r <= 1'b0;
    end else begin
      wr_start_r <= pkt_yumi_o & pkt_i.write_not_read;
      rd_start_r <= pkt_yumi_o & ~pkt_i.write_not_read;
      if (pkt_yumi_o)
        busy_r <= 1'b1;
      else if (wr_done_i | rd_done_i)
        busy_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pkt_yumi_o)
      addr_r <= remap_addr;
  end

endmodule

//--- dma_fifo.sv
// ##########################################################
// two-entry fifo, payload type set per instance
// ##########################################################

module dma_fifo
  #(parameter type payload_t = logic)
  (
    input  logic     clk_i
    , input  logic     reset_i

    , input  payload_t data_i
    , input  logic     v_i
    , output logic     ready_o

    , output payload_t data_o
    , output logic     v_o
    , input  logic     yumi_i
  );

  payload_t mem_r [2];

  logic wptr_r;
  logic rptr_r;
  logic full_r;
  logic empty;
  logic enq;
  logic deq;

  assign empty   = (wptr_r == rptr_r) & ~full_r;
  assign v_o     = ~empty;
  assign data_o  = mem_r[rptr_r];

  // a pop frees a slot in the same cycle
  assign ready_o = ~full_r | yumi_i;

  assign enq = v_i & ready_o;
  assign deq = v_o & yumi_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r <= 1'b0;
      rptr_r <= 1'b0;
      full_r <= 1'b0;
    end else begin
      if (enq)
        wptr_r <= ~wptr_r;
      if (deq)
        rptr_r <= ~rptr_r;
      if (enq & ~deq)
        full_r <= (~wptr_r == rptr_r);
      else if (deq & ~enq)
        full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq)
      mem_r[wptr_r] <= data_i;
  end

endmodule

//--- mem_channel_asserts.sv
// ##########################################################
// AXI request assertions for the memory channel top
// address stability, wlast framing, one burst at a time
// ##########################################################

module mem_channel_asserts
  import mem_channel_pkg::*;
  (
    input  logic      clk_i
    , input  logic      reset_i
    , input  axi_addr_t axi_awaddr_o
    , input  logic      axi_awvalid_o
    , input  logic      axi_awready_i
    , input  logic      axi_wlast_o
    , input  logic      axi_wvalid_o
    , input  axi_addr_t axi_araddr_o
    , input  logic      axi_arvalid_o
    , input  logic      axi_arready_i
  );

  timeunit 1ns;
  timeprecision 1ps;

  // requests hold until accepted
  aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o && $stable(axi_awaddr_o))
    else $error("AW request dropped or changed before awready");

  ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_araddr_o))
    else $error("AR request dropped or changed before arready");

  wlast_framed: assert property (@(posedge clk_i) disable iff (reset_i)
    axi_wlast_o |-> axi_wvalid_o)
    else $error("wlast high without wvalid");

  one_request: assert property (@(posedge clk_i) disable iff (reset_i)
    !(axi_awvalid_o && axi_arvalid_o))
    else $error("AW and AR requests pending together");

endmodule

bind mem_channel_top mem_channel_asserts asserts_i (
  .clk_i(clk_i)
  ,.reset_i(reset_i)
  ,.axi_awaddr_o(axi_awaddr_o)
  ,.axi_awvalid_o(axi_awvalid_o)
  ,.axi_awready_i(axi_awready_i)
  ,.axi_wlast_o(axi_wlast_o)
  ,.axi_wvalid_o(axi_wvalid_o)
  ,.axi_araddr_o(axi_araddr_o)
  ,.axi_arvalid_o(axi_arvalid_o)
  ,.axi_arready_i(axi_arready_i)
);

//--- mem_channel_pkg.sv
// ##########################################################
// shared widths and types of the memory channel
// data word, DMA and AXI addresses, source coordinate,
// the DMA packet and the burst length of one block
// ##########################################################

package mem_channel_pkg;

  // one DMA word is one AXI beat
  localparam int data_width_c = 32;

  // byte addresses
  localparam int dma_addr_width_c = 28;
  localparam int axi_addr_width_c = 32;

  // requesting cache coordinate
  localparam int cord_width_c = 8;

  // beats per cache block
  localparam int burst_len_c = 4;

  // wide enough to hold burst_len_c itself
  localparam int beat_cnt_width_c = $clog2(burst_len_c + 1);

  typedef logic [data_width_c-1:0] word_t;

  typedef logic [dma_addr_width_c-1:0] dma_addr_t;

  typedef logic [axi_addr_width_c-1:0] axi_addr_t;

  typedef logic [cord_width_c-1:0] cord_t;

  // request from one cache DMA port, already parsed
  typedef struct packed {
    logic      write_not_read;
    dma_addr_t addr;
    cord_t     src_cord;
  } dma_pkt_t;

endpackage

//--- mem_channel_top.sv
// ##########################################################
// memory channel top: packet queue, dispatcher, write and
// read burst engines and the read data buffer
// ##########################################################

module mem_channel_top
  import mem_channel_pkg::*;
  #(parameter mem_size_lg_p = 20
    , parameter vcache_sel_width_p = 3
    , parameter ruche_sel_width_p = 1
  )
  (
    input  logic      clk_i
    , input  logic      reset_i

    , input  dma_pkt_t  dma_pkt_i
    , input  logic      dma_pkt_v_i
    , output logic      dma_pkt_yumi_o

    , input  word_t     dma_wdata_i
    , input  logic      dma_wdata_v_i
    , output logic      dma_wdata_yumi_o

    , output word_t     dma_rdata_o
    , output logic      dma_rdata_v_o
    , input  logic      dma_rdata_ready_i

    , output axi_addr_t axi_awaddr_o
    , output logic      axi_awvalid_o
    , input  logic      axi_awready_i

    , output word_t     axi_wdata_o
    , output logic      axi_wlast_o
    , output logic      axi_wvalid_o
    , input  logic      axi_wready_i

    , input  logic      axi_bvalid_i
    , output logic      axi_bready_o

    , output axi_addr_t axi_araddr_o
    , output logic      axi_arvalid_o
    , input  logic      axi_arready_i

    , input  word_t     axi_rdata_i
    , input  logic      axi_rlast_i
    , input  logic      axi_rvalid_i
    , output logic      axi_rready_o
  );

  logic pkt_ready_lo;
  dma_pkt_t pkt_head_lo;
  logic pkt_head_v_lo;
  logic pkt_head_yumi_li;

  logic wr_start_lo;
  logic rd_start_lo;
  axi_addr_t burst_addr_lo;
  logic wr_done_lo;
  logic rd_done_lo;

  word_t rd_beat_lo;
  logic rd_beat_v_lo;
  logic rd_beat_ready_li;

  assign dma_pkt_yumi_o = pkt_ready_lo & dma_pkt_v_i;

  dma_fifo #(
    .payload_t(dma_pkt_t)
  ) pkt_fifo (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.data_i(dma_pkt_i)
    ,.v_i(dma_pkt_v_i)
    ,.ready_o(pkt_ready_lo)
    ,.data_o(pkt_head_lo)
    ,.v_o(pkt_head_v_lo)
    ,.yumi_i(pkt_head_yumi_li)
  );

  dma_dispatch #(
    .mem_size_lg_p(mem_size_lg_p)
    ,.vcache_sel_width_p(vcache_sel_width_p)
    ,.ruche_sel_width_p(ruche_sel_width_p)
  ) dispatch (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.pkt_i(pkt_head_lo)
    ,.pkt_v_i(pkt_head_v_lo)
    ,.pkt_yumi_o(pkt_head_yumi_li)
    ,.wr_start_o(wr_start_lo)
    ,.rd_start_o(rd_start_lo)
    ,.addr_o(burst_addr_lo)
    ,.wr_done_i(wr_done_lo)
    ,.rd_done_i(rd_done_lo)
  );

  axi_write_burst wr_engine (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.start_i(wr_start_lo)
    ,.addr_i(burst_addr_lo)
    ,.wdata_i(dma_wdata_i)
    ,.wdata_v_i(dma_wdata_v_i)
    ,.wdata_yumi_o(dma_wdata_yumi_o)
    ,.axi_awaddr_o(axi_awaddr_o)
    ,.axi_awvalid_o(axi_awvalid_o)
    ,.axi_awready_i(axi_awready_i)
    ,.axi_wdata_o(axi_wdata_o)
    ,.axi_wlast_o(axi_wlast_o)
    ,.axi_wvalid_o(axi_wvalid_o)
    ,.axi_wready_i(axi_wready_i)
    ,.axi_bvalid_i(axi_bvalid_i)
    ,.axi_bready_o(axi_bready_o)
    ,.done_o(wr_done_lo)
  );

  axi_read_burst rd_engine (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.start_i(rd_start_lo)
    ,.addr_i(burst_addr_lo)
    ,.axi_araddr_o(axi_araddr_o)
    ,.axi_arvalid_o(axi_arvalid_o)
    ,.axi_arready_i(axi_arready_i)
    ,.axi_rdata_i(axi_rdata_i)
    ,.axi_rlast_i(axi_rlast_i)
    ,.axi_rvalid_i(axi_rvalid_i)
    ,.axi_rready_o(axi_rready_o)
    ,.beat_o(rd_beat_lo)
    ,.beat_v_o(rd_beat_v_lo)
    ,.beat_ready_i(rd_beat_ready_li)
    ,.done_o(rd_done_lo)
  );

  // read beats wait here for the DMA port
  dma_fifo #(
    .payload_t(word_t)
  ) rdata_fifo (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.data_i(rd_beat_lo)
    ,.v_i(rd_beat_v_lo)
    ,.ready_o(rd_beat_ready_li)
    ,.data_o(dma_rdata_o)
    ,.v_o(dma_rdata_v_o)
    ,.yumi_i(dma_rdata_ready_i)
  );

endmodule

//--- run.sh
#!/bin/sh
# build and run the memory channel testbench
verilator --binary --timing --assert --top-module tb_mem_channel -f verilog.f -o sim_tb \
  && ./obj_dir/sim_tb \
  || exit 1

//--- tb_mem_channel.sv
// ##########################################################
// testbench for the memory channel: random DMA packets,
// an AXI memory model with random readies and valids,
// address, write beat and read data checks, a watchdog
// ##########################################################

module tb_mem_channel
  import mem_channel_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int mem_size_lg_lp = 20;
  localparam int vcache_sel_width_lp = 3;
  localparam int ruche_sel_width_lp = 1;
  localparam int offset_width_lp = mem_size_lg_lp - vcache_sel_width_lp;
  localparam int num_pkts_lp = 60;

  logic clk_i = 1'b0;
  logic reset_i;
  dma_pkt_t dma_pkt_i;
  logic dma_pkt_v_i;
  logic dma_pkt_yumi_o;
  word_t dma_wdata_i;
  logic dma_wdata_v_i;
  logic dma_wdata_yumi_o;
  word_t dma_rdata_o;
  logic dma_rdata_v_o;
  logic dma_rdata_ready_i;
  axi_addr_t axi_awaddr_o;
  logic axi_awvalid_o;
  logic axi_awready_i;
  word_t axi_wdata_o;
  logic axi_wlast_o;
  logic axi_wvalid_o;
  logic axi_wready_i;
  logic axi_bvalid_i;
  logic axi_bready_o;
  axi_addr_t axi_araddr_o;
  logic axi_arvalid_o;
  logic axi_arready_i;
  word_t axi_rdata_i;
  logic axi_rlast_i;
  logic axi_rvalid_i;
  logic axi_rready_o;

  logic [31:0] lcg_state;
  word_t mem_model [axi_addr_t];
  dma_pkt_t exp_pkt_q [$];
  word_t wdata_q [$];
  word_t rd_exp_q [$];
  axi_addr_t wr_addr;
  axi_addr_t rd_addr;
  int sent;
  int wr_beat;
  int rd_beat;
  logic wr_active;
  logic b_pend;
  logic rd_pend;
  logic r_fire;
  logic finished;

  always #20 clk_i = ~clk_i;

  mem_channel_top #(
    .mem_size_lg_p(mem_size_lg_lp)
    ,.vcache_sel_width_p(vcache_sel_width_lp)
    ,.ruche_sel_width_p(ruche_sel_width_lp)
  ) mem_channel_top_i (.*);

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // high about three cycles in four
  function automatic logic rand_ready();
    logic [31:0] r;
    r = next_rand();
    return r[17:16] != 2'b00;
  endfunction

  // few blocks and caches, so reads often hit earlier writes
  function automatic dma_pkt_t random_pkt();
    dma_pkt_t pkt;
    logic [31:0] r;
    r = next_rand();
    pkt.write_not_read = r[31];
    pkt.src_cord = r[23:16];
    r = next_rand();
    pkt.addr = {r[31:21], 11'b0, r[5:4], 4'b0000};
    return pkt;
  endfunction

  // cache slice select above the kept low address bits
  function automatic axi_addr_t expected_addr(dma_pkt_t pkt);
    logic [31:0] sel;
    logic [31:0] offset;
    sel = (32'(pkt.src_cord) >> ruche_sel_width_lp) & ((32'd1 << vcache_sel_width_lp) - 32'd1);
    offset = 32'(pkt.addr) & ((32'd1 << offset_width_lp) - 32'd1);
    return (sel << offset_width_lp) | offset;
  endfunction

  function automatic word_t mem_read(axi_addr_t addr);
    if (mem_model.exists(addr))
      return mem_model[addr];
    else
      return addr ^ 32'h3c5a96e1;
  endfunction

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(string name, axi_addr_t exp, axi_addr_t act);
    if (exp !== act)
      abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act)
      abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task monitor_axi();
    dma_pkt_t pkt;
    int i;
    if (axi_bvalid_i && axi_bready_o)
      b_pend = 1'b0;
    if (axi_awvalid_o && axi_awready_i) begin
      if (exp_pkt_q.size() == 0 || !exp_pkt_q[0].write_not_read)
        abort_run("AW request with no write packet next in order");
      pkt = exp_pkt_q.pop_front();
      check_addr("aw_addr", expected_addr(pkt), axi_awaddr_o);
      wr_addr = axi_awaddr_o;
      wr_beat = 0;
      wr_active = 1'b1;
    end
    if (axi_wvalid_o && axi_wready_i) begin
      if (!wr_active)
        abort_run("W beat outside of a write burst");
      if (!dma_wdata_yumi_o)
        abort_run("W beat sent without taking a DMA write word");
      if (wr_beat == burst_len_c - 1 && !axi_wlast_o)
        abort_run("wlast missing on the last beat of a write burst");
      if (wr_beat != burst_len_c - 1 && axi_wlast_o)
        abort_run("wlast high before the last beat of a write burst");
      check_word("w_data", wdata_q[0], axi_wdata_o);
      mem_model[wr_addr + axi_addr_t'(4 * wr_beat)] = wdata_q.pop_front();
      wr_beat++;
      if (wr_beat == burst_len_c) begin
        wr_active = 1'b0;
        b_pend = 1'b1;
      end
    end else if (dma_wdata_yumi_o) begin
      abort_run("DMA write word taken without a W beat");
    end
    if (axi_arvalid_o && axi_arready_i) begin
      if (exp_pkt_q.size() == 0 || exp_pkt_q[0].write_not_read)
        abort_run("AR request with no read packet next in order");
      pkt = exp_pkt_q.pop_front();
      check_addr("ar_addr", expected_addr(pkt), axi_araddr_o);
      rd_addr = axi_araddr_o;
      rd_beat = 0;
      rd_pend = 1'b1;
      for (i = 0; i < burst_len_c; i++)
        rd_exp_q.push_back(mem_read(rd_addr + axi_addr_t'(4 * i)));
    end
    r_fire = axi_rvalid_i && axi_rready_o;
    if (r_fire) begin
      rd_beat++;
      if (rd_beat == burst_len_c)
        rd_pend = 1'b0;
    end
  endtask

  task monitor_dma();
    int i;
    if (dma_rdata_v_o && dma_rdata_ready_i) begin
      if (rd_exp_q.size() == 0)
        abort_run("read beat on the DMA port with no read outstanding");
      check_word("r_data", rd_exp_q.pop_front(), dma_rdata_o);
    end
    if (dma_pkt_v_i && dma_pkt_yumi_o) begin
      exp_pkt_q.push_back(dma_pkt_i);
      if (dma_pkt_i.write_not_read) begin
        for (i = 0; i < burst_len_c; i++)
          wdata_q.push_back(next_rand());
      end
      sent++;
    end
  endtask

  task drive_inputs();
    axi_awready_i <= rand_ready();
    axi_wready_i <= rand_ready();
    axi_arready_i <= rand_ready();
    dma_rdata_ready_i <= rand_ready();
    axi_bvalid_i <= b_pend && (axi_bvalid_i || rand_ready());
    // R valid holds until the beat is taken
    axi_rvalid_i <= rd_pend && ((axi_rvalid_i && !r_fire) || rand_ready());
    axi_rdata_i <= mem_read(rd_addr + axi_addr_t'(4 * rd_beat));
    axi_rlast_i <= (rd_beat == burst_len_c - 1);
    if (!(dma_pkt_v_i && !dma_pkt_yumi_o)) begin
      dma_pkt_v_i <= (sent < num_pkts_lp) && rand_ready();
      dma_pkt_i <= random_pkt();
    end
    if (!(dma_wdata_v_i && !dma_wdata_yumi_o)) begin
      dma_wdata_v_i <= (wdata_q.size() > 0) && rand_ready();
      if (wdata_q.size() > 0)
        dma_wdata_i <= wdata_q[0];
    end
  endtask

  initial begin
    lcg_state = 32'h55c38cb1;
    sent = 0;
    wr_beat = 0;
    rd_beat = 0;
    wr_addr = '0;
    rd_addr = '0;
    wr_active = 1'b0;
    b_pend = 1'b0;
    rd_pend = 1'b0;
    r_fire = 1'b0;
    finished = 1'b0;
    reset_i <= 1'b1;
    dma_pkt_i <= '0;
    dma_pkt_v_i <= 1'b0;
    dma_wdata_i <= '0;
    dma_wdata_v_i <= 1'b0;
    dma_rdata_ready_i <= 1'b0;
    axi_awready_i <= 1'b0;
    axi_wready_i <= 1'b0;
    axi_bvalid_i <= 1'b0;
    axi_arready_i <= 1'b0;
    axi_rdata_i <= '0;
    axi_rlast_i <= 1'b0;
    axi_rvalid_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    if (dma_pkt_yumi_o || dma_wdata_yumi_o || dma_rdata_v_o
        || axi_awvalid_o || axi_wvalid_o || axi_arvalid_o)
      abort_run("a valid or yumi output is high after reset");
    while (!finished) begin
      @(posedge clk_i);
      monitor_axi();
      monitor_dma();
      drive_inputs();
      finished = (sent == num_pkts_lp) && (exp_pkt_q.size() == 0) && !wr_active
                 && !b_pend && !rd_pend && (rd_exp_q.size() == 0) && (wdata_q.size() == 0);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  // budget of 200 cycles per packet
  initial begin
    repeat (200 * num_pkts_lp) @(posedge clk_i);
    abort_run("timeout: packets did not finish in time");
  end

endmodule

//--- verilog.f
mem_channel_pkg.sv
dma_fifo.sv
dma_dispatch.sv
axi_write_burst.sv
axi_read_burst.sv
mem_channel_top.sv
mem_channel_asserts.sv
tb_mem_channel.sv
